//--- common/nn_types_pkg.sv
package nn_types_pkg;

  // Width of one weight value
  localparam int data_len = 8;

  // Values per memory word and per assembled block
  localparam int vals_per_word  = 9;
  localparam int vals_per_block = 36;

  typedef enum logic [2:0] {
    layer0 = 3'd0,
    layer1 = 3'd1,
    layer2 = 3'd2,
    layer3 = 3'd3,
    affine = 3'd4
  } layer_sel_t;

  typedef logic [2:0] phase_t;

  // One memory word with value 0 in the low bits
  typedef logic [vals_per_word*data_len-1:0] wword_t;

  // Four words with word 0 in the low bits
  typedef logic [vals_per_block*data_len-1:0] wblock_t;

endpackage

//--- common/weight_map_pkg.sv
package weight_map_pkg;

  // Block layout inside the weight memory
  localparam int words_per_block = 4;
  localparam int phase_stride    = 4;
  localparam int layer_stride    = 32;

  // Five layers of eight phases each
  localparam int wmem_depth  = 160;
  localparam int wmem_addr_w = 8;

  // Fetch lanes sharing the read port
  localparam int num_lanes  = 2;
  localparam int lane_idx_w = (num_lanes > 1) ? $clog2(num_lanes) : 1;

endpackage

//--- common/wmem_port_if.sv
`timescale 1ns/1ps

interface wmem_port_if
  import nn_types_pkg::*;
  import weight_map_pkg::*;
();

  logic                   req;
  logic [wmem_addr_w-1:0] addr;
  logic                   gnt;
  logic                   rvalid;
  wword_t                 rdata;

  // Data returns one cycle after req and gnt meet at an edge
  modport lane (
    output req, addr,
    input  gnt, rvalid, rdata
  );

  modport arb (
    input  req, addr,
    output gnt, rvalid, rdata
  );

endinterface

//--- weight_fetch/weight_ram.sv
`timescale 1ns/1ps

module weight_ram
  import nn_types_pkg::*;
  import weight_map_pkg::*;
(
  input  logic                   clk,
  input  logic                   wr_en,
  input  logic [wmem_addr_w-1:0] wr_addr,
  input  wword_t                 wr_data,
  input  logic                   rd_en,
  input  logic [wmem_addr_w-1:0] rd_addr,
  output wword_t                 rdata
);

  wword_t mem [wmem_depth];

  // Host write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read that misses a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[rd_addr];
    end
  end

endmodule

//--- weight_fetch/wmem_arbiter.sv
`timescale 1ns/1ps

module wmem_arbiter
  import nn_types_pkg::*;
  import weight_map_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  wmem_port_if.arb               lanes [num_lanes],
  output logic                   rd_en,
  output logic [wmem_addr_w-1:0] rd_addr,
  input  wword_t                 rdata
);

  logic [num_lanes-1:0]   req_vec;
  logic [wmem_addr_w-1:0] addr_arr [num_lanes];
  logic [num_lanes-1:0]   gnt_vec;
  logic [lane_idx_w-1:0]  rr_ptr;
  logic [lane_idx_w-1:0]  pick;
  logic                   found;
  logic                   rpend;
  logic [lane_idx_w-1:0]  rsel;

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign req_vec[i]      = lanes[i].req;
    assign addr_arr[i]     = lanes[i].addr;
    assign gnt_vec[i]      = found && (pick == lane_idx_w'(i));
    assign lanes[i].gnt    = gnt_vec[i];
    // Return path steered by last cycle's grant
    assign lanes[i].rvalid = rpend && (rsel == lane_idx_w'(i));
    assign lanes[i].rdata  = rdata;
  end

  // First requester at or after the pointer
  always_comb begin : pick_lane
    int idx;
    pick  = rr_ptr;
    found = 1'b0;
    for (int k = 0; k < num_lanes; k++) begin
      idx = (int'(rr_ptr) + k) % num_lanes;
      if (!found && req_vec[idx]) begin
        found = 1'b1;
        pick  = lane_idx_w'(idx);
      end
    end
  end

  assign rd_en   = found;
  assign rd_addr = addr_arr[pick];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_ptr <= '0;
      rpend  <= 1'b0;
      rsel   <= '0;
    end else begin
      rpend <= found;
      if (found) begin
        rsel <= pick;
        // Granted lane drops to lowest priority
        if (int'(pick) == num_lanes - 1) begin
          rr_ptr <= '0;
        end else begin
          rr_ptr <= pick + 1'b1;
        end
      end
    end
  end

endmodule

//--- weight_fetch/weight_fetch.sv
`timescale 1ns/1ps

module weight_fetch
  import nn_types_pkg::*;
  import weight_map_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       load,
  input  layer_sel_t layer,
  input  phase_t     phase,
  wmem_port_if.lane  mem,
  output logic       valid,
  output wblock_t    block
);

  localparam int word_w = $bits(wword_t);

  logic                   busy;
  logic [2:0]             issue_cnt;
  logic [2:0]             ret_cnt;
  layer_sel_t             layer_q;
  phase_t                 phase_q;
  logic [wmem_addr_w-1:0] base;

  assign base = wmem_addr_w'(int'(layer_q) * layer_stride + int'(phase_q) * phase_stride);

  // Address held until granted
  assign mem.req  = busy && (int'(issue_cnt) < words_per_block);
  assign mem.addr = base + wmem_addr_w'(issue_cnt);

  // Layer and phase frozen for the whole load
  always_ff @(posedge clk) begin
    if (load && !busy) begin
      layer_q <= layer;
      phase_q <= phase;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      issue_cnt <= '0;
      ret_cnt   <= '0;
      valid     <= 1'b0;
    end else if (!load) begin
      busy      <= 1'b0;
      issue_cnt <= '0;
      ret_cnt   <= '0;
      valid     <= 1'b0;
    end else if (!busy) begin
      busy <= 1'b1;
    end else begin
      if (mem.req && mem.gnt) begin
        issue_cnt <= issue_cnt + 3'd1;
      end
      if (mem.rvalid) begin
        ret_cnt <= ret_cnt + 3'd1;
      end
      if (int'(ret_cnt) == words_per_block) begin
        valid <= 1'b1;
      end
    end
  end

  // Returned words land in order of return
  always_ff @(posedge clk) begin
    if (load && busy && mem.rvalid && int'(ret_cnt) < words_per_block) begin
      block[ret_cnt*word_w +: word_w] <= mem.rdata;
    end
  end

endmodule

//--- rtl/weight_fetch_top.sv
`timescale 1ns/1ps

module weight_fetch_top
  import nn_types_pkg::*;
  import weight_map_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wr_en,
  input  logic [wmem_addr_w-1:0] wr_addr,
  input  wword_t                 wr_data,
  input  logic                   load_a,
  input  layer_sel_t             layer_a,
  input  phase_t                 phase_a,
  output logic                   valid_a,
  output wblock_t                block_a,
  input  logic                   load_b,
  input  layer_sel_t             layer_b,
  input  phase_t                 phase_b,
  output logic                   valid_b,
  output wblock_t                block_b
);

  logic                   rd_en;
  logic [wmem_addr_w-1:0] rd_addr;
  wword_t                 rdata;

  // One read port per lane
  wmem_port_if lane_port [num_lanes] ();

  weight_fetch u_lane_a (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load_a),
    .layer  (layer_a),
    .phase  (phase_a),
    .mem    (lane_port[0]),
    .valid  (valid_a),
    .block  (block_a)
  );

  weight_fetch u_lane_b (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load_b),
    .layer  (layer_b),
    .phase  (phase_b),
    .mem    (lane_port[1]),
    .valid  (valid_b),
    .block  (block_b)
  );

  wmem_arbiter u_arb (
    .clk     (clk),
    .arst_n  (arst_n),
    .lanes   (lane_port),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rdata   (rdata)
  );

  weight_ram u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rdata   (rdata)
  );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real period     = 40.0,
  parameter int  rst_cycles = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  // Reset held over the first rising edges
  initial begin
    arst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

//--- sim/tb_weight_fetch.sv
`timescale 1ns/1ps

module tb_weight_fetch
  import nn_types_pkg::*;
  import weight_map_pkg::*;
();

  localparam int fetch_limit     = 50;
  localparam int num_fetches     = 56;
  localparam int watchdog_cycles = num_fetches * fetch_limit + 400;
  localparam int word_w          = $bits(wword_t);

  logic                   clk;
  logic                   arst_n;
  logic                   wr_en;
  logic [wmem_addr_w-1:0] wr_addr;
  wword_t                 wr_data;
  logic                   load_a;
  layer_sel_t             layer_a;
  phase_t                 phase_a;
  logic                   valid_a;
  wblock_t                block_a;
  logic                   load_b;
  layer_sel_t             layer_b;
  phase_t                 phase_b;
  logic                   valid_b;
  wblock_t                block_b;

  // Copy of every word written to the DUT memory
  wword_t  model [wmem_depth];
  wblock_t exp_a [$];
  wblock_t exp_b [$];
  int      seed;
  int      checks_done = 0;
  string   test_name = "reset";
  logic    seen_a = 1'b0;
  logic    seen_b = 1'b0;

  tb_clock #(.period(40.0), .rst_cycles(4)) u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  weight_fetch_top u_weight_fetch_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .load_a  (load_a),
    .layer_a (layer_a),
    .phase_a (phase_a),
    .valid_a (valid_a),
    .block_a (block_a),
    .load_b  (load_b),
    .layer_b (layer_b),
    .phase_b (phase_b),
    .valid_b (valid_b),
    .block_b (block_b)
  );

  // Four words from layer * 32 + phase * 4 with word 0 lowest
  function automatic wblock_t ref_block(input layer_sel_t l, input phase_t p);
    int      base;
    wblock_t blk;
    base = int'(l) * layer_stride + int'(p) * phase_stride;
    for (int w = 0; w < words_per_block; w++) begin
      blk[w*word_w +: word_w] = model[base + w];
    end
    return blk;
  endfunction

  function automatic wword_t rand_word();
    wword_t w;
    w[31:0]  = $random(seed);
    w[63:32] = $random(seed);
    w[71:64] = 8'($random(seed));
    return w;
  endfunction

  function automatic logic lane_valid(input int lane);
    return (lane == 0) ? valid_a : valid_b;
  endfunction

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_block(input string name, input wblock_t exp, input wblock_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_lane(input int lane);
    wblock_t exp;
    if ((lane == 0 && exp_a.size() == 0) || (lane == 1 && exp_b.size() == 0)) begin
      $display("Lane %0d raised valid with no fetch outstanding", lane);
      stop_on_error();
    end else if (lane == 0) begin
      exp = exp_a.pop_front();
      check_block({test_name, " lane a"}, exp, block_a);
      checks_done++;
    end else begin
      exp = exp_b.pop_front();
      check_block({test_name, " lane b"}, exp, block_b);
      checks_done++;
    end
  endtask

  // Checks each new block on the rising edge of valid
  always @(negedge clk) begin : compare_results
    if (valid_a === 1'b1 && !seen_a) begin
      compare_lane(0);
    end
    if (valid_b === 1'b1 && !seen_b) begin
      compare_lane(1);
    end
    seen_a = (valid_a === 1'b1);
    seen_b = (valid_b === 1'b1);
  end

  task automatic write_word(input int addr, input wword_t data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= wmem_addr_w'(addr);
    wr_data <= data;
    model[addr] = data;
  endtask

  task automatic write_end();
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic start_fetch(input int lane, input layer_sel_t l, input phase_t p);
    if (lane == 0) begin
      exp_a.push_back(ref_block(l, p));
      load_a  <= 1'b1;
      layer_a <= l;
      phase_a <= p;
    end else begin
      exp_b.push_back(ref_block(l, p));
      load_b  <= 1'b1;
      layer_b <= l;
      phase_b <= p;
    end
  endtask

  task automatic wait_valid(input int lane);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (lane_valid(lane) !== 1'b1) begin
      cycles++;
      if (cycles >= fetch_limit) begin
        $display("Lane %0d never completed its fetch in %0d cycles (%s)",
                 lane, fetch_limit, test_name);
        stop_on_error();
      end
      @(negedge clk);
    end
  endtask

  // Valid must be low one edge after load falls
  task automatic stop_loads();
    logic had_a;
    logic had_b;
    @(posedge clk);
    had_a = load_a;
    had_b = load_b;
    load_a <= 1'b0;
    load_b <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (had_a) begin
      check_valid({test_name, " valid_a drop"}, 1'b0, valid_a);
    end
    if (had_b) begin
      check_valid({test_name, " valid_b drop"}, 1'b0, valid_b);
    end
  endtask

  task automatic fetch_one(input int lane, input layer_sel_t l, input phase_t p);
    test_name = $sformatf("lane %0d layer %0d phase %0d", lane, l, p);
    @(posedge clk);
    start_fetch(lane, l, p);
    wait_valid(lane);
    stop_loads();
  endtask

  task automatic fetch_pair(input layer_sel_t la, input phase_t pa,
                            input layer_sel_t lb, input phase_t pb);
    test_name = $sformatf("pair a %0d/%0d b %0d/%0d", la, pa, lb, pb);
    @(posedge clk);
    start_fetch(0, la, pa);
    start_fetch(1, lb, pb);
    wait_valid(0);
    wait_valid(1);
    stop_loads();
  endtask

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d clock cycles", watchdog_cycles);
    stop_on_error();
  end

  initial begin : stimulus
    int addr;
    int rw_addr [10];
    seed    = 32'he034_b962;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    load_a  = 1'b0;
    layer_a = layer0;
    phase_a = '0;
    load_b  = 1'b0;
    layer_b = layer0;
    phase_b = '0;

    wait (arst_n === 1'b1);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_valid("reset valid_a", 1'b0, valid_a);
    check_valid("reset valid_b", 1'b0, valid_b);

    for (int a = 0; a < wmem_depth; a++) begin
      write_word(a, rand_word());
    end
    write_end();

    // Every layer and phase on lane a alone
    for (int l = 0; l < 5; l++) begin
      for (int p = 0; p < 8; p++) begin
        fetch_one(0, layer_sel_t'(l), phase_t'(p));
      end
    end

    fetch_pair(layer1, 3'd2, layer3, 3'd5);
    fetch_pair(affine, 3'd7, affine, 3'd7);
    fetch_pair(layer0, 3'd0, layer0, 3'd1);
    fetch_pair(layer2, 3'd4, layer2, 3'd4);

    // Layer and phase changes under a held load
    test_name = "hold";
    @(posedge clk);
    start_fetch(0, layer1, 3'd3);
    @(posedge clk);
    layer_a <= affine;
    phase_a <= 3'd6;
    wait_valid(0);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_valid("hold valid_a", 1'b1, valid_a);
    check_block("hold block_a", ref_block(layer1, 3'd3), block_a);
    stop_loads();
    fetch_one(0, affine, 3'd6);
    fetch_one(1, layer3, 3'd1);

    // Words 41 and 43 sit in layer 1 phase 2
    write_word(41, rand_word());
    write_word(43, rand_word());
    for (int i = 0; i < 10; i++) begin
      rw_addr[i] = int'($unsigned($random(seed)) % wmem_depth);
      write_word(rw_addr[i], rand_word());
    end
    write_end();
    fetch_one(0, layer1, 3'd2);
    for (int j = 0; j < 4; j++) begin
      addr = rw_addr[j];
      fetch_one(j % 2, layer_sel_t'(addr / layer_stride),
                phase_t'((addr % layer_stride) / phase_stride));
    end

    repeat (2) @(posedge clk);
    if (checks_done != num_fetches) begin
      $display("Only %0d of %0d fetches were checked", checks_done, num_fetches);
      stop_on_error();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- build.f
common/nn_types_pkg.sv
common/weight_map_pkg.sv
common/wmem_port_if.sv
weight_fetch/weight_ram.sv
weight_fetch/wmem_arbiter.sv
weight_fetch/weight_fetch.sv
rtl/weight_fetch_top.sv
sim/tb_clock.sv
sim/tb_weight_fetch.sv
